// ==== include/fpAdd_defs.svh ====
// FP adder field widths
`ifndef FPADD_DEFS_SVH
`define FPADD_DEFS_SVH

`define FP_EXP_W      8
`define FP_MAN_W      23
`define FP_GUARD_W    8
`define FP_ALIGN_W    32   // hidden + fraction + guard.
`define FP_BIAS       127
`define FP_MAX_SHIFT  32

// canonical quiet NaN.
`define FP_QNAN       32'h7FC0_0000

`endif

// ==== hdl/fpAddPkg.sv ====
// FP adder stage types
`default_nettype none
`include "fpAdd_defs.svh"

package fpAddPkg;

    // one unpacked operand.
    typedef struct packed
    {
        logic                  sign;
        logic [`FP_EXP_W-1:0]  exponent;
        logic [`FP_MAN_W-1:0]  mantissa;
        logic                  isNaN;
        logic                  isInf;
        logic                  isZero;
        logic                  isSub;
    } fpFields_t;

    typedef struct packed
    {
        logic [`FP_ALIGN_W-1:0] alignedMantissaA;
        logic [`FP_ALIGN_W-1:0] alignedMantissaB;
        logic [`FP_EXP_W-1:0]   exponentOut;    // effective exponent of larger operand.
        logic                   aLarger;
        logic                   bLarger;
        logic                   shiftOverflow;  // set bits fell out of the frame.
        logic                   sticky;         // anything below the round bit.
        logic                   bypass;
    } alignOut_t;

    typedef struct packed
    {
        logic [`FP_EXP_W+`FP_MAN_W:0] word;
        logic                         valid;
    } fpResult_t;

endpackage

`default_nettype wire

// ==== hdl/operandUnpack.sv ====
// IEEE single unpack
`timescale 1ns/1ps
`default_nettype none
`include "fpAdd_defs.svh"

module operandUnpack
(
    input  logic [`FP_EXP_W+`FP_MAN_W:0] word,
    output fpAddPkg::fpFields_t          fields
);

    logic expAllOnes;
    logic expZero;
    logic manZero;

    assign expAllOnes = &word[`FP_EXP_W+`FP_MAN_W-1:`FP_MAN_W];
    assign expZero    = ~|word[`FP_EXP_W+`FP_MAN_W-1:`FP_MAN_W];
    assign manZero    = ~|word[`FP_MAN_W-1:0];

    always_comb
    begin
        fields.sign     = word[`FP_EXP_W+`FP_MAN_W];
        fields.exponent = word[`FP_EXP_W+`FP_MAN_W-1:`FP_MAN_W];
        fields.mantissa = word[`FP_MAN_W-1:0];

        fields.isNaN  = expAllOnes & ~manZero;
        fields.isInf  = expAllOnes & manZero;
        fields.isZero = expZero & manZero;
        fields.isSub  = expZero & ~manZero;   // hidden bit is 0.
    end

endmodule

`default_nettype wire

// ==== hdl/alignment.sv ====
// Exponent compare and mantissa align
`timescale 1ns/1ps
`default_nettype none
`include "fpAdd_defs.svh"

module alignment
(
    input  fpAddPkg::fpFields_t a,
    input  fpAddPkg::fpFields_t b,
    output fpAddPkg::alignOut_t align
);

    logic [`FP_EXP_W-1:0]     effExpA;
    logic [`FP_EXP_W-1:0]     effExpB;
    logic [`FP_EXP_W-1:0]     exponentDifferential;
    logic [`FP_ALIGN_W-1:0]   frameA;
    logic [`FP_ALIGN_W-1:0]   frameB;
    logic [`FP_ALIGN_W-1:0]   smallFrame;
    logic [2*`FP_ALIGN_W-1:0] shiftedWide;
    logic                     specialOperand;

    // subnormals sit at an exponent of 1.
    assign effExpA = a.isSub ? {{(`FP_EXP_W-1){1'b0}}, 1'b1} : a.exponent;
    assign effExpB = b.isSub ? {{(`FP_EXP_W-1){1'b0}}, 1'b1} : b.exponent;

    assign frameA = {~a.isSub, a.mantissa, {`FP_GUARD_W{1'b0}}};
    assign frameB = {~b.isSub, b.mantissa, {`FP_GUARD_W{1'b0}}};

    assign align.aLarger = (a.exponent > b.exponent);
    assign align.bLarger = (a.exponent < b.exponent);

    always_comb
    begin
        if (align.aLarger)
        begin
            align.exponentOut    = effExpA;
            exponentDifferential = effExpA - effExpB;
            smallFrame           = frameB;
        end
        else if (align.bLarger)
        begin
            align.exponentOut    = effExpB;
            exponentDifferential = effExpB - effExpA;
            smallFrame           = frameA;
        end
        else
        begin
            align.exponentOut    = effExpA;
            exponentDifferential = '0;
            smallFrame           = frameA;   // unshifted, nothing lost.
        end
    end

    // upper half is the aligned frame, lower half the bits shifted out.
    assign shiftedWide = {smallFrame, {`FP_ALIGN_W{1'b0}}} >> exponentDifferential;

    always_comb
    begin
        align.alignedMantissaA = frameA;
        align.alignedMantissaB = frameB;
        if (align.aLarger)
            align.alignedMantissaB = shiftedWide[2*`FP_ALIGN_W-1:`FP_ALIGN_W];
        else if (align.bLarger)
            align.alignedMantissaA = shiftedWide[2*`FP_ALIGN_W-1:`FP_ALIGN_W];
    end

    assign align.shiftOverflow = |shiftedWide[`FP_ALIGN_W-1:0];

    // round bit is the top guard bit; everything under it counts.
    assign align.sticky = |shiftedWide[`FP_ALIGN_W+`FP_GUARD_W-2:0];

    assign specialOperand = a.isNaN | b.isNaN | a.isInf | b.isInf | a.isZero | b.isZero;

    assign align.bypass = specialOperand | (exponentDifferential >= `FP_MAX_SHIFT);

endmodule

`default_nettype wire

// ==== hdl/specialCase.sv ====
// Bypass result for special operands
`timescale 1ns/1ps
`default_nettype none
`include "fpAdd_defs.svh"

module specialCase
(
    input  fpAddPkg::fpFields_t a,
    input  fpAddPkg::fpFields_t b,
    input  logic                bypass,
    output fpAddPkg::fpResult_t special
);

    logic [`FP_EXP_W+`FP_MAN_W:0]   wordA;
    logic [`FP_EXP_W+`FP_MAN_W:0]   wordB;
    logic [`FP_EXP_W+`FP_MAN_W-1:0] magA;
    logic [`FP_EXP_W+`FP_MAN_W-1:0] magB;
    logic                           infClash;

    assign wordA = {a.sign, a.exponent, a.mantissa};
    assign wordB = {b.sign, b.exponent, b.mantissa};
    assign magA  = wordA[`FP_EXP_W+`FP_MAN_W-1:0];
    assign magB  = wordB[`FP_EXP_W+`FP_MAN_W-1:0];

    assign infClash = a.isInf & b.isInf & (a.sign ^ b.sign);

    always_comb
    begin
        special.valid = bypass;

        if (a.isNaN | b.isNaN | infClash)
            special.word = `FP_QNAN;
        else if (a.isInf)
            special.word = wordA;
        else if (b.isInf)
            special.word = wordB;
        else if (a.isZero & b.isZero)
            special.word = {a.sign & b.sign, {(`FP_EXP_W+`FP_MAN_W){1'b0}}};
        else if (a.isZero)
            special.word = wordB;
        else if (b.isZero)
            special.word = wordA;
        else if (magA >= magB)
            special.word = wordA;   // other operand is below a quarter ulp.
        else
            special.word = wordB;
    end

endmodule

`default_nettype wire

// ==== hdl/mantissaAddNormalize.sv ====
// Mantissa add, normalize and round
`timescale 1ns/1ps
`default_nettype none
`include "fpAdd_defs.svh"

module mantissaAddNormalize
(
    input  fpAddPkg::alignOut_t align,
    input  logic                signA,
    input  logic                signB,
    output fpAddPkg::fpResult_t sum
);

    localparam int EXP_MAX = 2*`FP_BIAS + 1;

    logic                       effSub;
    logic                       swap;
    logic                       resultSign;
    logic [`FP_ALIGN_W:0]       bigExt;
    logic [`FP_ALIGN_W:0]       smallExt;
    logic [`FP_ALIGN_W+1:0]     rawSum;
    logic [5:0]                 leadPos;
    logic [5:0]                 shiftDist;
    logic [`FP_ALIGN_W:0]       normMant;
    logic signed [`FP_EXP_W+1:0] expIn;
    logic signed [`FP_EXP_W+1:0] normExp;
    logic signed [`FP_EXP_W+1:0] finalExp;
    logic                       guardBit;
    logic                       stickyBit;
    logic                       roundUp;
    logic [`FP_MAN_W+1:0]       rounded;
    logic [`FP_MAN_W:0]         finalMant;

    assign effSub = signA ^ signB;

    // equal exponents fall back to a mantissa compare.
    assign swap = align.bLarger |
                  (~align.aLarger & (align.alignedMantissaB > align.alignedMantissaA));

    assign resultSign = swap ? signB : signA;

    // lost bits ride along as one jam bit under the frame.
    always_comb
    begin
        if (swap)
        begin
            bigExt   = {align.alignedMantissaB, 1'b0};
            smallExt = {align.alignedMantissaA, align.shiftOverflow};
        end
        else
        begin
            bigExt   = {align.alignedMantissaA, 1'b0};
            smallExt = {align.alignedMantissaB, align.shiftOverflow};
        end
    end

    assign rawSum = effSub ? ({1'b0, bigExt} - {1'b0, smallExt})
                           : ({1'b0, bigExt} + {1'b0, smallExt});

    assign expIn = $signed({2'b00, align.exponentOut});

    always_comb
    begin
        leadPos = '0;
        for (int i = 0; i <= `FP_ALIGN_W; i++)
        begin
            if (rawSum[i])
                leadPos = 6'(i);
        end
    end

    assign shiftDist = 6'(`FP_ALIGN_W) - leadPos;

    always_comb
    begin
        if (rawSum[`FP_ALIGN_W+1])
        begin
            normMant    = rawSum[`FP_ALIGN_W+1:1];
            normMant[0] = rawSum[1] | rawSum[0];   // keep the dropped bit sticky.
            normExp     = expIn + 1;
        end
        else
        begin
            normMant = rawSum[`FP_ALIGN_W:0] << shiftDist;
            normExp  = expIn - $signed({4'b0000, shiftDist});
        end
    end

    // nearest-even on the normalized frame.
    always_comb
    begin
        guardBit  = normMant[`FP_GUARD_W];
        stickyBit = (|normMant[`FP_GUARD_W-1:0]) | (align.sticky & ~effSub);
        roundUp   = guardBit & (stickyBit | normMant[`FP_GUARD_W+1]);
        rounded   = {1'b0, normMant[`FP_ALIGN_W:`FP_GUARD_W+1]} + roundUp;

        if (rounded[`FP_MAN_W+1])
        begin
            finalMant = rounded[`FP_MAN_W+1:1];
            finalExp  = normExp + 1;
        end
        else
        begin
            finalMant = rounded[`FP_MAN_W:0];
            finalExp  = normExp;
        end
    end

    always_comb
    begin
        sum.valid = ~align.bypass;

        if (rawSum == '0)
            sum.word = '0;   // exact cancellation is +0.
        else if (finalExp >= EXP_MAX)
            sum.word = {resultSign, {`FP_EXP_W{1'b1}}, {`FP_MAN_W{1'b0}}};
        else if (finalExp < 1)
            sum.word = {resultSign, {(`FP_EXP_W+`FP_MAN_W){1'b0}}};
        else
            sum.word = {resultSign, finalExp[`FP_EXP_W-1:0], finalMant[`FP_MAN_W-1:0]};
    end

endmodule

`default_nettype wire

// ==== hdl/resultSelect.sv ====
// Result mux and output register
`timescale 1ns/1ps
`default_nettype none
`include "fpAdd_defs.svh"

module resultSelect
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         strobe,
    input  fpAddPkg::fpResult_t          special,
    input  fpAddPkg::fpResult_t          sum,
    output logic                         outValid,
    output logic [`FP_EXP_W+`FP_MAN_W:0] result
);

    logic [`FP_EXP_W+`FP_MAN_W:0] chosen;

    // bypass result wins whenever it is flagged.
    assign chosen = special.valid ? special.word : sum.word;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            outValid <= 1'b0;
            result   <= '0;
        end
        else
        begin
            outValid <= strobe;
            if (strobe)
                result <= chosen;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fpAdder.sv ====
// Pipelined FP adder top
`timescale 1ns/1ps
`default_nettype none
`include "fpAdd_defs.svh"

module fpAdder
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         inValid,
    input  logic [`FP_EXP_W+`FP_MAN_W:0] opA,
    input  logic [`FP_EXP_W+`FP_MAN_W:0] opB,
    input  logic                         sub,
    output logic                         outValid,
    output logic [`FP_EXP_W+`FP_MAN_W:0] result
);

    logic                         validQ;
    logic [`FP_EXP_W+`FP_MAN_W:0] opAQ;
    logic [`FP_EXP_W+`FP_MAN_W:0] opBQ;
    fpAddPkg::fpFields_t          fieldsA;
    fpAddPkg::fpFields_t          fieldsB;
    fpAddPkg::alignOut_t          alignBus;
    fpAddPkg::fpResult_t          specialResult;
    fpAddPkg::fpResult_t          sumResult;

    always_ff @(posedge clk)
    begin
        if (rst)
            validQ <= 1'b0;
        else
            validQ <= inValid;
    end

    always_ff @(posedge clk)
    begin
        if (inValid)
        begin
            opAQ <= opA;
            opBQ <= {opB[`FP_EXP_W+`FP_MAN_W] ^ sub, opB[`FP_EXP_W+`FP_MAN_W-1:0]};  // a - b = a + (-b).
        end
    end

    operandUnpack unpackA (.word(opAQ), .fields(fieldsA));
    operandUnpack unpackB (.word(opBQ), .fields(fieldsB));

    alignment alignStage (.a(fieldsA), .b(fieldsB), .align(alignBus));

    specialCase specialStage
    (
        .a       (fieldsA),
        .b       (fieldsB),
        .bypass  (alignBus.bypass),
        .special (specialResult)
    );

    mantissaAddNormalize addStage
    (
        .align (alignBus),
        .signA (fieldsA.sign),
        .signB (fieldsB.sign),
        .sum   (sumResult)
    );

    resultSelect selectStage
    (
        .clk      (clk),
        .rst      (rst),
        .strobe   (validQ),
        .special  (specialResult),
        .sum      (sumResult),
        .outValid (outValid),
        .result   (result)
    );

endmodule

`default_nettype wire

// ==== verification/fpAdderTb.sv ====
// FP adder testbench
`timescale 1ns/1ps
`default_nettype none
`include "fpAdd_defs.svh"

module fpAdderTb;

    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_VECTORS  = 64;
    localparam int GROUP_SIZE   = 6;
    localparam int GAP_CYCLES   = 3;
    localparam int W            = `FP_EXP_W + `FP_MAN_W + 1;

    typedef struct packed
    {
        logic [W-1:0] a;
        logic [W-1:0] b;
        logic         sub;
        logic [W-1:0] expected;
    } vector_t;

    logic         clk;
    logic         rst;
    logic         inValid;
    logic [W-1:0] opA;
    logic [W-1:0] opB;
    logic         sub;
    logic         outValid;
    logic [W-1:0] result;

    logic [W-1:0] rawWords [0:4*MAX_VECTORS-1];
    vector_t      vectors [0:MAX_VECTORS-1];
    int           numVectors = 0;
    int           checkedCount = 0;
    int           cycle = 0;
    int           popIndex;
    int           popCycle;
    int           pendingIndex [$];
    int           pendingCycle [$];

    fpAdder fpAdder_inst
    (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .opA      (opA),
        .opB      (opB),
        .sub      (sub),
        .outValid (outValid),
        .result   (result)
    );

    task automatic checkValue(input string what, input logic [W-1:0] expected,
                              input logic [W-1:0] actual);
        if (actual !== expected)
        begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, what, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    always @(posedge clk)
        cycle <= cycle + 1;   // edges seen so far.

    initial
    begin
        rst     = 1'b1;
        inValid = 1'b0;
        opA     = '0;
        opB     = '0;
        sub     = 1'b0;
        $readmemh("verification/fpAdder_tests.txt", rawWords);
        while (numVectors < MAX_VECTORS && !$isunknown(rawWords[4*numVectors]))
        begin
            vectors[numVectors] = {rawWords[4*numVectors], rawWords[4*numVectors+1],
                                   rawWords[4*numVectors+2][0], rawWords[4*numVectors+3]};
            numVectors++;
        end
        if (numVectors == 0)
        begin
            $display("No test vectors could be read from the data file");
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        rst = 1'b0;
        for (int i = 0; i < numVectors; i++)
        begin
            if (i > 0 && i % GROUP_SIZE == 0)
            begin
                inValid = 1'b0;   // idle gap between groups.
                repeat (GAP_CYCLES) @(posedge clk);
                #10;
            end
            opA     = vectors[i].a;
            opB     = vectors[i].b;
            sub     = vectors[i].sub;
            inValid = 1'b1;
            pendingIndex.push_back(i);
            pendingCycle.push_back(cycle);
            @(posedge clk);
            #10;
        end
        inValid = 1'b0;
        wait (checkedCount == numVectors);
        repeat (4) @(posedge clk);   // catch stray outputs.
        $display("TESTBENCH PASSED");
        $finish;
    end

    // outputs sampled mid-cycle.
    always @(negedge clk)
    begin
        if (rst)
        begin
            if (cycle > 0)
                checkValue("outValid during reset", '0, W'(outValid));
        end
        else if (outValid !== 1'b0)
        begin
            if (pendingIndex.size() == 0)
            begin
                $display("Unexpected output at %0t ns with no operation in flight", $time);
                $display("TESTBENCH FAILED");
                $fatal(1);
            end
            popIndex = pendingIndex.pop_front();
            popCycle = pendingCycle.pop_front();
            checkValue($sformatf("vector %0d outValid", popIndex), W'(1), W'(outValid));
            checkValue($sformatf("vector %0d result", popIndex),
                       vectors[popIndex].expected, result);
            checkValue($sformatf("vector %0d latency", popIndex), W'(popCycle + 2), W'(cycle));
            checkedCount++;
        end
    end

    initial
    begin
        wait (numVectors > 0 && rst == 1'b0);
        #((numVectors + (numVectors / GROUP_SIZE) * GAP_CYCLES + 20) * PERIOD);
        $display("Timeout: not all results arrived in the expected time");
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
hdl/fpAddPkg.sv
hdl/operandUnpack.sv
hdl/alignment.sv
hdl/specialCase.sv
hdl/mantissaAddNormalize.sv
hdl/resultSelect.sv
hdl/fpAdder.sv
verification/fpAdderTb.sv

// ==== verification/fpAdder_tests.txt ====
// columns: opA opB sub expected, all hex
// sub 1 means opA - opB
3F800000 40000000 0 40400000
3FC00000 3E800000 1 3FA00000
40A00000 40400000 1 40000000
40400000 40A00000 1 C0000000
3F800000 33800000 0 3F800000
3F800001 33800000 0 3F800002
3F800000 33800001 1 3F7FFFFF
3F800001 3F800000 1 34000000
3FC00000 3FC00000 1 00000000
3FC00000 3FC00000 0 40400000
7F800001 3F800000 0 7FC00000
7F800000 7F800000 1 7FC00000
7F800000 C2C80000 0 7F800000
3F800000 7F800000 1 FF800000
00000000 40490FDB 0 40490FDB
80000000 80000000 0 80000000
4F800000 3F800000 0 4F800000
3F800000 4F800000 1 CF800000
7F7FFFFF 7F7FFFFF 0 7F800000
FF7FFFFF 7F7FFFFF 1 FF800000
80800001 00800000 0 80000000
00400000 00800000 0 00C00000
00000001 00800000 0 00800001
